/* project.f */
+incdir+.
pwConvPkg.sv
pwStreamIf.sv
pwInstrLatch.sv
pwParamLoader.sv
pwMacArray.sv
pwQuantizer.sv
pwStrideSelect.sv
pwConvTop.sv
tbPwConv.sv

/* pwConvPkg.sv */
`default_nettype none

`include "pwConv_config.svh"

package pwConvPkg;

    // one pixel, eight channels of one byte
    typedef logic [`PW_BEAT_W-1:0] pixelBeat_t;

    typedef logic signed [`PW_DATA_W-1:0] weight_t;
    typedef logic signed [`PW_ACC_W-1:0] acc_t;

    // eight sums side by side, channel 0 in the low word
    typedef logic [`PW_COUT*`PW_ACC_W-1:0] accVec_t;

    // per-channel requant params
    typedef logic [15:0] scale_t;
    typedef logic [4:0] shift_t;

    typedef logic [`PW_ROW_W-1:0] rowCount_t;
    typedef logic signed [`PW_DATA_W-1:0] zeroPoint_t;

    // parameter loader fsm
    typedef enum logic [1:0] {IDLE, WEIGHTS, NORM, DONE} loadState_t;

endpackage

`default_nettype wire

/* pwConvTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

module pwConvTop import pwConvPkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [3:0]  sign,
    input  wire logic [31:0] reg4,
    input  wire logic [31:0] reg5,
    input  wire logic [31:0] reg6,
    input  wire logic [31:0] reg7,
    input  wire logic        startCompute,
    input  wire pixelBeat_t  paramData,
    input  wire logic        paramValid,
    output logic             paramReady,
    input  wire pixelBeat_t  sData,
    input  wire logic        sValid,
    output logic             sReady,
    output pixelBeat_t       mData,
    output logic             mValid,
    input  wire logic        mReady,
    output logic             mLast,
    output logic             writeBlockComplete,
    output logic             convComplete
);

    // decoded instruction fields
    rowCount_t rowNumOut;
    logic strideEn;
    logic leakyEn;
    zeroPoint_t zeroPoint;

    // loaded parameter tables
    weight_t [`PW_COUT-1:0][`PW_CIN-1:0] weights;
    acc_t [`PW_COUT-1:0] biasTable;
    scale_t [`PW_COUT-1:0] scaleTable;
    shift_t [`PW_COUT-1:0] shiftTable;

    //////////////////////////////
    // mac to quantizer, quantizer to stride
    pwStreamIf #(.DataW(`PW_COUT*`PW_ACC_W)) accIf ();
    pwStreamIf #(.DataW(`PW_BEAT_W)) pixIf ();

    pwInstrLatch pwInstrLatch_i (
        .clk(clk), .rst(rst), .sign(sign),
        .reg4(reg4), .reg5(reg5), .reg6(reg6), .reg7(reg7),
        .rowNumOut(rowNumOut), .strideEn(strideEn),
        .leakyEn(leakyEn), .zeroPoint(zeroPoint)
    );

    pwParamLoader pwParamLoader_i (
        .clk(clk), .rst(rst), .startCompute(startCompute),
        .paramData(paramData), .paramValid(paramValid), .paramReady(paramReady),
        .writeBlockComplete(writeBlockComplete), .weights(weights),
        .biasTable(biasTable), .scaleTable(scaleTable), .shiftTable(shiftTable)
    );

    pwMacArray pwMacArray_i (
        .clk(clk), .rst(rst), .sData(sData), .sValid(sValid), .sReady(sReady),
        .weights(weights), .accOut(accIf.source)
    );

    pwQuantizer pwQuantizer_i (
        .clk(clk), .rst(rst), .accIn(accIf.sink), .pixOut(pixIf.source),
        .biasTable(biasTable), .scaleTable(scaleTable), .shiftTable(shiftTable),
        .leakyEn(leakyEn), .zeroPoint(zeroPoint)
    );

    pwStrideSelect pwStrideSelect_i (
        .clk(clk), .rst(rst), .startCompute(startCompute), .strideEn(strideEn),
        .rowNumOut(rowNumOut), .pixIn(pixIf.sink), .mData(mData), .mValid(mValid),
        .mReady(mReady), .mLast(mLast), .convComplete(convComplete)
    );

endmodule

`default_nettype wire

/* pwConv_config.svh */
`ifndef PW_CONV_CONFIG_SVH
`define PW_CONV_CONFIG_SVH

// channel counts of one pixel beat
`define PW_CIN 8
`define PW_COUT 8

// element width, one signed byte per channel
`define PW_DATA_W 8

// mac sum width
`define PW_ACC_W 32

// one weight block plus one norm block
`define PW_PARAM_BEATS 16

// feature map side, square maps only
`define PW_ROW_W 11

// stream word, eight bytes
`define PW_BEAT_W 64

`endif

/* pwInstrLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module pwInstrLatch import pwConvPkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [3:0] sign,
    input  wire logic [31:0] reg4,
    input  wire logic [31:0] reg5,
    input  wire logic [31:0] reg6,
    input  wire logic [31:0] reg7,
    output rowCount_t       rowNumOut,
    output logic            strideEn,
    output logic            leakyEn,
    output zeroPoint_t      zeroPoint
);

    // sign code for the compute instruction
    localparam logic [3:0] SignCompute = 4'd2;

    // reg7 high, reg4 low
    logic [127:0] instrWord;

    // words sampled every cycle
    always_ff @(posedge clk) begin
        instrWord <= {reg7, reg6, reg5, reg4};
    end

    //////////////////////////////
    // field capture
    always_ff @(posedge clk) begin
        if (rst) begin
            rowNumOut <= '0;
            strideEn  <= 1'b0;
            leakyEn   <= 1'b0;
            zeroPoint <= '0;
        end else if (sign == SignCompute) begin
            // reg4 bits 21..11
            rowNumOut <= instrWord[21:11];
            // reg5 bit 29
            strideEn  <= instrWord[61];
            // reg5 bit 25
            leakyEn   <= instrWord[57];
            // reg7 bits 23..16
            zeroPoint <= instrWord[119:112];
        end
        // other codes keep the active fields
    end

endmodule

`default_nettype wire

/* pwMacArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

module pwMacArray import pwConvPkg::*; (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire pixelBeat_t                     sData,
    input  wire logic                           sValid,
    output logic                                sReady,
    input  wire weight_t [`PW_COUT-1:0][`PW_CIN-1:0] weights,
    pwStreamIf.source                           accOut
);

    // combinational sums for the beat at the input
    accVec_t dotVec;
    // one-slot output stage
    accVec_t slotData;
    logic slotValid;
    logic take;

    // signed dot product of one pixel with one weight row
    function automatic acc_t dotRow(
        input pixelBeat_t pix,
        input weight_t [`PW_CIN-1:0] row
    );
        acc_t sum;
        weight_t px;
        weight_t wt;
        sum = '0;
        for (int j = 0; j < `PW_CIN; j++) begin
            px = pix[j*`PW_DATA_W +: `PW_DATA_W];
            wt = row[j];
            // product sign extends to the sum width
            sum = sum + px * wt;
        end
        return sum;
    endfunction

    // one row per output channel
    always_comb begin
        for (int k = 0; k < `PW_COUT; k++) begin
            dotVec[k*`PW_ACC_W +: `PW_ACC_W] = dotRow(sData, weights[k]);
        end
    end

    //////////////////////////////
    // slot handshake
    // ready when empty or draining this cycle
    assign sReady = !slotValid || accOut.ready;
    assign take = sValid && sReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
        end else if (take) begin
            slotValid <= 1'b1;
        end else if (accOut.ready) begin
            slotValid <= 1'b0;
        end
    end

    // held under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            slotData <= dotVec;
        end
    end

    assign accOut.valid = slotValid;
    assign accOut.data  = slotData;
    // no framing at the input, the stride stage owns frame ends
    assign accOut.last  = 1'b0;

endmodule

`default_nettype wire

/* pwParamLoader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

module pwParamLoader import pwConvPkg::*; (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             startCompute,
    input  wire pixelBeat_t                       paramData,
    input  wire logic                             paramValid,
    output logic                                  paramReady,
    output logic                                  writeBlockComplete,
    output weight_t [`PW_COUT-1:0][`PW_CIN-1:0]   weights,
    output acc_t [`PW_COUT-1:0]                   biasTable,
    output scale_t [`PW_COUT-1:0]                 scaleTable,
    output shift_t [`PW_COUT-1:0]                 shiftTable
);

    localparam int CntW = $clog2(`PW_PARAM_BEATS);
    localparam int RowIdxW = $clog2(`PW_COUT);
    // first half of the block is weight rows
    localparam int RowBeats = `PW_COUT;

    loadState_t state;
    loadState_t nextState;
    logic [CntW-1:0] beatCnt;
    logic [RowIdxW-1:0] rowIdx;
    logic accept;
    logic lastBeat;

    assign accept = paramValid && paramReady;
    assign lastBeat = beatCnt == CntW'(`PW_PARAM_BEATS - 1);
    // output channel of this beat
    assign rowIdx = beatCnt[RowIdxW-1:0];

    //////////////////////////////
    // load fsm
    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (accept) nextState = WEIGHTS;
            WEIGHTS: if (accept && beatCnt == CntW'(RowBeats - 1)) nextState = NORM;
            NORM:    if (accept && lastBeat) nextState = DONE;
            // only a finished block is re-armed
            DONE:    if (startCompute) nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            beatCnt            <= '0;
            paramReady         <= 1'b0;
            writeBlockComplete <= 1'b0;
        end else begin
            state              <= nextState;
            // ready follows the state it enters
            paramReady         <= nextState != DONE;
            writeBlockComplete <= accept && lastBeat;
            if (accept) begin
                beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // table writes
    always_ff @(posedge clk) begin
        if (accept) begin
            if (beatCnt < CntW'(RowBeats)) begin
                // input channel j sits in byte j
                weights[rowIdx] <= paramData;
            end else begin
                biasTable[rowIdx]  <= paramData[31:0];
                scaleTable[rowIdx] <= paramData[47:32];
                shiftTable[rowIdx] <= paramData[52:48];
            end
        end
    end

endmodule

`default_nettype wire

/* pwQuantizer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

module pwQuantizer import pwConvPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    pwStreamIf.sink                    accIn,
    pwStreamIf.source                  pixOut,
    input  wire acc_t [`PW_COUT-1:0]   biasTable,
    input  wire scale_t [`PW_COUT-1:0] scaleTable,
    input  wire shift_t [`PW_COUT-1:0] shiftTable,
    input  wire logic                  leakyEn,
    input  wire zeroPoint_t            zeroPoint
);

    // 32 x 16 product, sign kept
    localparam int ProdW = 48;

    logic signed [ProdW-1:0] prodNext [`PW_COUT];
    logic signed [ProdW-1:0] prodReg [`PW_COUT];
    logic v1, last1, ready1;
    pixelBeat_t pixNext;
    pixelBeat_t pixReg;
    logic v2, last2, ready2;

    // (acc + bias) * scale
    function automatic logic signed [ProdW-1:0] scaleOne(
        input acc_t acc,
        input acc_t bias,
        input scale_t scale
    );
        acc_t biased;
        biased = acc + bias;
        return biased * $signed({1'b0, scale});
    endfunction

    // shift, leaky, zero point, clamp to a signed byte
    function automatic logic [`PW_DATA_W-1:0] requant(
        input logic signed [ProdW-1:0] prod,
        input shift_t sh,
        input logic leaky,
        input zeroPoint_t zp
    );
        logic signed [ProdW-1:0] shifted;
        logic signed [ProdW:0] withZp;
        shifted = prod >>> sh;
        // leaky slope of 1/8
        if (leaky && shifted < 0) begin
            shifted = shifted >>> 3;
        end
        withZp = shifted + zp;
        if (withZp > 127) return 8'h7f;
        if (withZp < -128) return 8'h80;
        return withZp[`PW_DATA_W-1:0];
    endfunction

    always_comb begin
        for (int k = 0; k < `PW_COUT; k++) begin
            prodNext[k] = scaleOne(accIn.data[k*`PW_ACC_W +: `PW_ACC_W], biasTable[k],
                                   scaleTable[k]);
            pixNext[k*`PW_DATA_W +: `PW_DATA_W] = requant(prodReg[k], shiftTable[k],
                                                          leakyEn, zeroPoint);
        end
    end

    //////////////////////////////
    // two slots, ready passed back
    assign ready2 = !v2 || pixOut.ready;
    assign ready1 = !v1 || ready2;
    assign accIn.ready = ready1;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            // stage 1 slot
            if (accIn.valid && ready1) v1 <= 1'b1;
            else if (ready2) v1 <= 1'b0;
            // stage 2 slot
            if (v1 && ready2) v2 <= 1'b1;
            else if (pixOut.ready) v2 <= 1'b0;
        end
    end

    // payload moves only with its slot
    always_ff @(posedge clk) begin
        if (accIn.valid && ready1) begin
            prodReg <= prodNext;
            last1   <= accIn.last;
        end
        if (v1 && ready2) begin
            pixReg <= pixNext;
            last2  <= last1;
        end
    end

    assign pixOut.valid = v2;
    assign pixOut.data  = pixReg;
    assign pixOut.last  = last2;

endmodule

`default_nettype wire

/* pwStreamIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

// valid/ready stream, one beat per cycle with both high
interface pwStreamIf #(
    parameter int DataW = `PW_BEAT_W
);

    logic             valid;
    logic             ready;
    logic [DataW-1:0] data;
    // end of frame tag
    logic             last;

    // producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* pwStrideSelect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

module pwStrideSelect import pwConvPkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      startCompute,
    input  wire logic      strideEn,
    input  wire rowCount_t rowNumOut,
    pwStreamIf.sink        pixIn,
    output pixelBeat_t     mData,
    output logic           mValid,
    input  wire logic      mReady,
    output logic           mLast,
    output logic           convComplete
);

    rowCount_t colCnt;
    rowCount_t rowCnt;
    rowCount_t lastIdx;
    rowCount_t lastKept;
    logic accept, keep;
    logic colEnd, rowEnd, frameEnd, isLastKept;

    // last index of a row, same for columns
    assign lastIdx = rowNumOut - rowCount_t'(1);
    // under stride the last even index is the last kept one
    assign lastKept = strideEn ? {lastIdx[`PW_ROW_W-1:1], 1'b0} : lastIdx;

    // one slot in front of the outputs
    assign pixIn.ready = !mValid || mReady;
    assign accept = pixIn.valid && pixIn.ready;

    // odd row or odd column dropped
    assign keep = !strideEn || (!rowCnt[0] && !colCnt[0]);
    assign colEnd = colCnt == lastIdx;
    assign rowEnd = rowCnt == lastIdx;
    assign frameEnd = (colEnd && rowEnd) || pixIn.last;
    assign isLastKept = keep && rowCnt == lastKept && colCnt == lastKept;

    //////////////////////////////
    // position counters
    always_ff @(posedge clk) begin
        if (rst || startCompute) begin
            colCnt <= '0;
            rowCnt <= '0;
        end else if (accept) begin
            if (frameEnd) begin
                colCnt <= '0;
                rowCnt <= '0;
            end else if (colEnd) begin
                colCnt <= '0;
                rowCnt <= rowCnt + 1'b1;
            end else begin
                colCnt <= colCnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // output slot
    always_ff @(posedge clk) begin
        if (rst) begin
            mValid       <= 1'b0;
            mLast        <= 1'b0;
            convComplete <= 1'b0;
        end else begin
            // pulse after the tagged beat leaves
            convComplete <= mValid && mReady && mLast;
            if (accept && keep) begin
                mValid <= 1'b1;
                mLast  <= isLastKept || pixIn.last;
            end else if (mReady) begin
                mValid <= 1'b0;
                mLast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && keep) begin
            mData <= pixIn.data;
        end
    end

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# build and run the pointwise conv testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tbPwConv \
    && ./obj_dir/VtbPwConv > sim.log 2>&1 \
    || echo "build or run error"
cat sim.log 2>/dev/null
# verdict from the log only
grep -qx "sim passed" sim.log && echo "result: ok" || { echo "result: failure"; exit 1; }

/* tbPwConv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwConv_config.svh"

module tbPwConv import pwConvPkg::*; ();

    localparam int NumCases = 6;
    // edges allowed per wait loop
    localparam int WaitLimit = 200;
    localparam int FrameLimit = 2000;

    // one row of the stimulus table
    typedef struct packed {
        logic [10:0] rows;
        logic        stride;
        logic        leaky;
        logic [7:0]  zp;
        logic [3:0]  sign;
        logic        randParams;
        logic        randReady;
        logic        checkLatency;
    } caseEntry_t;

    logic clk;
    logic rst;
    logic [3:0] sign;
    logic [31:0] reg4;
    logic [31:0] reg5;
    logic [31:0] reg6;
    logic [31:0] reg7;
    logic startCompute;
    pixelBeat_t paramData;
    logic paramValid;
    logic paramReady;
    pixelBeat_t sData;
    logic sValid;
    logic sReady;
    pixelBeat_t mData;
    logic mValid;
    logic mReady;
    logic mLast;
    logic writeBlockComplete;
    logic convComplete;

    caseEntry_t cases [NumCases];
    string caseName [NumCases];

    // model copy of the loaded tables
    int wTab [`PW_COUT][`PW_CIN];
    int biasTab [`PW_COUT];
    int scaleTab [`PW_COUT];
    int shiftTab [`PW_COUT];

    // fields the DUT should hold right now
    int actRows;
    logic actStride;
    logic actLeaky;
    logic signed [7:0] actZp;

    // frame buffers
    pixelBeat_t inPix [64];
    pixelBeat_t expPix [64];
    int acceptAt [64];
    int outAt [64];

    int caseErr;
    int passCount;
    int failCount;
    int testNum;
    logic hung;

    pwConvTop pwConvTop_i (
        .clk(clk), .rst(rst), .sign(sign),
        .reg4(reg4), .reg5(reg5), .reg6(reg6), .reg7(reg7),
        .startCompute(startCompute),
        .paramData(paramData), .paramValid(paramValid), .paramReady(paramReady),
        .sData(sData), .sValid(sValid), .sReady(sReady),
        .mData(mData), .mValid(mValid), .mReady(mReady), .mLast(mLast),
        .writeBlockComplete(writeBlockComplete), .convComplete(convComplete)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // reference model and checks
    // mac, bias, scale, shift, leaky, zero point, clamp
    function automatic pixelBeat_t quantPixel(
        input pixelBeat_t pix,
        input logic leakyOn,
        input logic signed [7:0] zpVal
    );
        int acc;
        longint v;
        logic signed [7:0] pb;
        pixelBeat_t res;
        for (int k = 0; k < `PW_COUT; k++) begin
            acc = 0;
            for (int j = 0; j < `PW_CIN; j++) begin
                pb = pix[j*8 +: 8];
                acc = acc + int'(pb) * wTab[k][j];
            end
            v = (longint'(acc) + longint'(biasTab[k])) * longint'(scaleTab[k]);
            v = v >>> shiftTab[k];
            // negative side gets a further divide by 8
            if (leakyOn && v < 0) v = v >>> 3;
            v = v + longint'(zpVal);
            if (v > 127) v = 127;
            else if (v < -128) v = -128;
            res[k*8 +: 8] = v[7:0];
        end
        return res;
    endfunction

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            caseErr++;
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input string name);
        if (caseErr == 0) begin
            passCount++;
            $display("test %0d %s: ok", testNum, name);
        end else begin
            failCount++;
            $display("test %0d %s: %0d errors", testNum, name, caseErr);
        end
        testNum++;
        caseErr = 0;
    endtask

    // rows, stride, leaky, zp, sign code, random params, random ready, latency check
    task automatic fillTable();
        cases[0] = '{11'd3, 1'b0, 1'b0, 8'h00, 4'd2, 1'b0, 1'b0, 1'b1};
        cases[1] = '{11'd4, 1'b0, 1'b1, 8'h05, 4'd2, 1'b1, 1'b0, 1'b0};
        // zero point -20
        cases[2] = '{11'd3, 1'b0, 1'b0, 8'hec, 4'd2, 1'b1, 1'b0, 1'b0};
        cases[3] = '{11'd4, 1'b1, 1'b0, 8'h00, 4'd2, 1'b0, 1'b0, 1'b0};
        // zero point -3, random sink stalls
        cases[4] = '{11'd5, 1'b0, 1'b1, 8'hfd, 4'd2, 1'b1, 1'b1, 1'b0};
        // code 1 must not touch the fields of case 4
        cases[5] = '{11'd2, 1'b1, 1'b0, 8'h63, 4'd1, 1'b1, 1'b0, 1'b0};
        caseName[0] = "identity path";
        caseName[1] = "quantization leaky";
        caseName[2] = "quantization zero point";
        caseName[3] = "stride 2";
        caseName[4] = "back-pressure";
        caseName[5] = "instruction capture";
    endtask

    //////////////////////////////
    // stimulus tasks
    task automatic programInstr(input caseEntry_t e);
        logic [31:0] w4;
        logic [31:0] w5;
        logic [31:0] w7;
        // noise around the decoded bits
        w4 = $urandom;
        w5 = $urandom;
        w7 = $urandom;
        w4[21:11] = e.rows;
        w5[25] = e.leaky;
        w5[29] = e.stride;
        w7[23:16] = e.zp;
        reg4 <= w4;
        reg5 <= w5;
        reg6 <= $urandom;
        reg7 <= w7;
        // words registered first, sign one cycle later
        @(posedge clk);
        sign <= e.sign;
        @(posedge clk);
        sign <= 4'd0;
        if (e.sign == 4'd2) begin
            actRows = int'(e.rows);
            actStride = e.stride;
            actLeaky = e.leaky;
            actZp = e.zp;
        end
    endtask

    task automatic loadParams(input logic randOn);
        pixelBeat_t beat [`PW_PARAM_BEATS];
        logic signed [7:0] wByte;
        int waitCnt;
        int pulses;
        int readyAfter;
        logic accepted;
        for (int k = 0; k < `PW_COUT; k++) begin
            for (int j = 0; j < `PW_CIN; j++) begin
                if (randOn) wByte = 8'($urandom);
                else wByte = (k == j) ? 8'sd1 : 8'sd0;
                wTab[k][j] = int'(wByte);
                beat[k][j*8 +: 8] = wByte;
            end
            if (!randOn) begin
                biasTab[k] = 0;
                scaleTab[k] = 1;
                shiftTab[k] = 0;
            end else if (k < 2) begin
                // channel 0 pinned high, channel 1 pinned low
                biasTab[k] = (k == 0) ? 1000000 : -1000000;
                scaleTab[k] = 255;
                shiftTab[k] = 4;
            end else begin
                biasTab[k] = int'($urandom % 8192) - 4096;
                scaleTab[k] = int'($urandom % 1024) + 1;
                shiftTab[k] = int'($urandom % 12) + 8;
            end
            // unused top bits left random
            beat[k + `PW_COUT] = {$urandom, $urandom};
            beat[k + `PW_COUT][31:0] = 32'(biasTab[k]);
            beat[k + `PW_COUT][47:32] = 16'(scaleTab[k]);
            beat[k + `PW_COUT][52:48] = 5'(shiftTab[k]);
        end
        // re-arm the loader and clear the frame counters
        startCompute <= 1'b1;
        @(posedge clk);
        startCompute <= 1'b0;
        pulses = 0;
        for (int b = 0; b < `PW_PARAM_BEATS && !hung; b++) begin
            paramData <= beat[b];
            paramValid <= 1'b1;
            accepted = 1'b0;
            waitCnt = 0;
            while (!accepted && !hung) begin
                @(posedge clk);
                pulses += int'(writeBlockComplete);
                if (paramReady) begin
                    accepted = 1'b1;
                end else if (waitCnt++ > WaitLimit) begin
                    $display("timeout: parameter beat %0d was never accepted", b);
                    caseErr++;
                    hung = 1'b1;
                end
            end
        end
        paramValid <= 1'b0;
        readyAfter = 0;
        // pulse lands on the first of these edges
        repeat (4) begin
            @(posedge clk);
            pulses += int'(writeBlockComplete);
            readyAfter += int'(paramReady);
        end
        if (!hung) begin
            checkEq(pulses, 1, "writeBlockComplete pulses");
            checkEq(readyAfter, 0, "paramReady high after block");
        end
    endtask

    task automatic runFrame(input logic randReady, input logic checkLatency);
        int nIn;
        int nExp;
        int inIdx;
        int outIdx;
        int cyc;
        int convAt;
        int lastOutAt;
        int lateValid;
        logic convSeen;
        pixelBeat_t pix;
        nIn = actRows * actRows;
        nExp = 0;
        for (int i = 0; i < nIn; i++) begin
            pix = {$urandom, $urandom};
            inPix[i] = pix;
            // row major, stride keeps even row and column
            if (!actStride || ((i / actRows) % 2 == 0 && (i % actRows) % 2 == 0)) begin
                expPix[nExp] = quantPixel(pix, actLeaky, actZp);
                nExp++;
            end
        end
        inIdx = 0;
        outIdx = 0;
        cyc = 0;
        convAt = 0;
        lastOutAt = 0;
        convSeen = 1'b0;
        sData <= inPix[0];
        sValid <= 1'b1;
        mReady <= 1'b1;
        while ((outIdx < nExp || inIdx < nIn || !convSeen) && !hung) begin
            @(posedge clk);
            cyc++;
            // source side
            if (sValid && sReady) begin
                acceptAt[inIdx] = cyc;
                inIdx++;
            end
            // held until taken, gaps only in the stall test
            if (!sValid || sReady) begin
                if (inIdx < nIn && (!randReady || $urandom % 4 != 0)) begin
                    sData <= inPix[inIdx];
                    sValid <= 1'b1;
                end else begin
                    sValid <= 1'b0;
                end
            end
            // sink side
            if (mValid && mReady) begin
                if (outIdx < nExp) begin
                    checkEq(mData, expPix[outIdx], "output pixel");
                    checkEq(mLast, outIdx == nExp - 1, "mLast");
                    outAt[outIdx] = cyc;
                end else begin
                    $display("%0t: more output pixels than the %0d expected", $time, nExp);
                    caseErr++;
                end
                outIdx++;
                lastOutAt = cyc;
            end
            if (convComplete && !convSeen) begin
                convSeen = 1'b1;
                convAt = cyc;
            end
            mReady <= randReady ? (($urandom % 3) != 0) : 1'b1;
            if (cyc > FrameLimit) begin
                $display("timeout: frame stalled with %0d of %0d outputs", outIdx, nExp);
                caseErr++;
                hung = 1'b1;
            end
        end
        if (!hung) begin
            checkEq(outIdx, nExp, "output count");
            checkEq(convAt, lastOutAt + 1, "convComplete cycle");
            if (checkLatency) begin
                for (int i = 0; i < nExp; i++) begin
                    checkEq(outAt[i] - acceptAt[i], 4, "input to output latency");
                end
            end
        end
        // quiet window, nothing left in flight
        mReady <= 1'b1;
        lateValid = 0;
        repeat (6) begin
            @(posedge clk);
            lateValid += int'(mValid) + int'(convComplete);
        end
        checkEq(lateValid, 0, "activity after frame end");
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        void'($urandom(32'he8eb_3d58));
        clk = 1'b0;
        rst = 1'b1;
        sign = 4'd0;
        reg4 = '0;
        reg5 = '0;
        reg6 = '0;
        reg7 = '0;
        startCompute = 1'b0;
        paramData = '0;
        paramValid = 1'b0;
        sData = '0;
        sValid = 1'b0;
        mReady = 1'b1;
        actRows = 0;
        actStride = 1'b0;
        actLeaky = 1'b0;
        actZp = '0;
        caseErr = 0;
        passCount = 0;
        failCount = 0;
        testNum = 0;
        hung = 1'b0;
        fillTable();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // values left by reset
        checkEq(paramReady, 0, "paramReady after reset");
        checkEq(mValid, 0, "mValid after reset");
        checkEq(writeBlockComplete, 0, "writeBlockComplete after reset");
        checkEq(convComplete, 0, "convComplete after reset");
        checkEq(sReady, 1, "sReady after reset");
        reportTest("reset values");

        for (int c = 0; c < NumCases && !hung; c++) begin
            programInstr(cases[c]);
            loadParams(cases[c].randParams);
            if (!hung) runFrame(cases[c].randReady, cases[c].checkLatency);
            reportTest(caseName[c]);
        end

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && !hung) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
